// ==== uart_frame_pkg.sv ====
// serial frame format shared by the receiver RTL and its testbench
// character and bit count types plus the oversampling ratio of the baud tick

package uart_frame_pkg;

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------

  // received character, bit 7 reads zero in 7-bit mode
  typedef logic [7:0] data_t;

  // number of bits sampled in one frame, data plus parity
  typedef logic [3:0] bit_cnt_t;

  // ------------------------------------------------------------------------
  // format constants
  // ------------------------------------------------------------------------

  localparam int OVERSAMPLE = 16;  // baud ticks per bit period

  localparam bit_cnt_t DATA_BITS_7 = 4'd7;
  localparam bit_cnt_t DATA_BITS_8 = 4'd8;

endpackage

// ==== uart_rx_pkg.sv ====
// receiver-internal definitions, used by the frame state machine only
// tick positions inside a bit period and the frame states

package uart_rx_pkg;

  // position within one bit period, counts baud ticks
  typedef logic [3:0] sample_cnt_t;

  typedef enum logic [1:0] {
    rx_idle,       // waiting for a start bit
    rx_data_bits,  // shifting in data and parity
    rx_stop_bit,   // checking the stop bit
    rx_wait        // waiting for the line to go high again
  } rx_state_e;

  // ------------------------------------------------------------------------
  // tick counts within a bit
  // ------------------------------------------------------------------------
  localparam sample_cnt_t START_CONFIRM = 4'd8;   // half a bit of low line
  localparam sample_cnt_t SAMPLE_POINT  = 4'd15;  // middle of the next bit
  localparam sample_cnt_t STOP_CHECK    = 4'd14;
  localparam sample_cnt_t WAIT_LIMIT    = 4'd6;   // give up on a stuck low line

endpackage

// ==== rx_majority_filter.sv ====
// glitch filter for the raw serial line
// keeps the last three samples taken on baud_tick and outputs their majority,
// so a single bad sample never reaches the frame logic

module rx_majority_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,
  input  logic rx,
  output logic rx_filtered
);

  logic [2:0] history;  // newest sample in bit 2

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      history <= 3'b111;  // idle line is high
    end
    else if (baud_tick)
    begin
      history <= {rx, history[2:1]};
    end
  end

  // two out of three
  always_comb
  begin
    rx_filtered = (history[0] & history[1]) |
                  (history[1] & history[2]) |
                  (history[0] & history[2]);
  end

endmodule

// ==== rx_frame_fsm.sv ====
// frame state machine of the receiver
// finds the start bit, samples data and parity bits in mid-bit, checks the stop
// bit and waits for the line to return high. result pulses are single cycles
// aligned to baud_tick

module rx_frame_fsm
  import uart_frame_pkg::*, uart_rx_pkg::*;
(
  input  logic  clk,
  input  logic  aresetn,
  input  logic  baud_tick,
  input  logic  rx_filtered,
  input  logic  bit8,
  input  logic  parity_en,
  output logic  frame_start,
  output logic  bit_sample,
  output logic  parity_slot,
  output logic  frame_done,
  output data_t frame_data,
  output logic  stop_bad
);

  rx_state_e   state;
  sample_cnt_t tick_cnt;  // ticks into the current bit
  bit_cnt_t    bit_cnt;   // bits sampled so far
  bit_cnt_t    last_bit;  // total bits in this frame, data plus parity
  logic        par_q;     // parity enabled for this frame
  logic [8:0]  shift_q;   // newest bit enters at the top

  logic [8:0]  aligned;
  bit_cnt_t    data_bits;

  // ------------------------------------------------------------------------
  // state, tick counter and bit counter
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= rx_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      last_bit <= DATA_BITS_8;
      par_q    <= 1'b0;
    end
    else if (baud_tick)
    begin
      tick_cnt <= tick_cnt + 4'd1;
      case (state)
        rx_idle:
        begin
          bit_cnt <= '0;
          if (rx_filtered)
          begin
            tick_cnt <= '0;  // high line restarts the start search
          end
          else if (tick_cnt == START_CONFIRM)
          begin
            tick_cnt <= '0;
            state    <= rx_data_bits;
            last_bit <= (bit8 ? DATA_BITS_8 : DATA_BITS_7) + {3'b000, parity_en};
            par_q    <= parity_en;
          end
        end
        rx_data_bits:
        begin
          if (bit_cnt == last_bit)
            state <= rx_stop_bit;
          else if (tick_cnt == SAMPLE_POINT)
            bit_cnt <= bit_cnt + 4'd1;
        end
        rx_stop_bit:
        begin
          if (tick_cnt == SAMPLE_POINT)
            state <= rx_wait;
        end
        default:  // rx_wait
        begin
          if (rx_filtered || tick_cnt == WAIT_LIMIT)
          begin
            state    <= rx_idle;
            tick_cnt <= '0;
          end
        end
      endcase
    end
  end

  // data shift register
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      shift_q <= '0;
    end
    else if (bit_sample)
    begin
      shift_q <= {rx_filtered, shift_q[8:1]};
    end
  end

  // ------------------------------------------------------------------------
  // pulses and output data
  // ------------------------------------------------------------------------
  assign frame_start = baud_tick && state == rx_idle && !rx_filtered &&
                       tick_cnt == START_CONFIRM;
  assign bit_sample  = baud_tick && state == rx_data_bits &&
                       bit_cnt != last_bit && tick_cnt == SAMPLE_POINT;
  assign parity_slot = bit_sample && par_q && (bit_cnt + 4'd1 == last_bit);
  assign frame_done  = baud_tick && state == rx_data_bits && bit_cnt == last_bit;
  assign stop_bad    = baud_tick && state == rx_stop_bit &&
                       tick_cnt == STOP_CHECK && !rx_filtered;

  // first data bit down to bit 0, parity bit lands above the data
  assign aligned   = shift_q >> (4'd9 - last_bit);
  assign data_bits = last_bit - {3'b000, par_q};
  assign frame_data = {aligned[7] & (data_bits != DATA_BITS_7), aligned[6:0]};

endmodule

// ==== rx_parity_check.sv ====
// parity checker running next to the frame state machine
// folds every sampled data bit into a running parity and compares it with the
// parity bit when that one is sampled

module rx_parity_check (
  input  logic clk,
  input  logic aresetn,
  input  logic odd_n_even,
  input  logic rx_filtered,
  input  logic frame_start,
  input  logic bit_sample,
  input  logic parity_slot,
  output logic parity_bad
);

  logic running;  // xor of data bits seen in this frame

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      running    <= 1'b0;
      parity_bad <= 1'b0;
    end
    else
    begin
      parity_bad <= 1'b0;
      if (frame_start)
      begin
        running <= 1'b0;
      end
      else if (bit_sample && !parity_slot)
      begin
        running <= running ^ rx_filtered;
      end
      else if (bit_sample && parity_slot)
      begin
        // even: total ones must be even, odd: must be odd
        parity_bad <= running ^ rx_filtered ^ odd_n_even;
      end
    end
  end

endmodule

// ==== rx_status_regs.sv ====
// status registers of the receiver
// holds the received byte and the sticky full, overflow, parity and framing
// flags. a set on the same cycle as its clear wins

module rx_status_regs
  import uart_frame_pkg::*;
(
  input  logic  clk,
  input  logic  aresetn,
  input  logic  frame_done,
  input  data_t frame_data,
  input  logic  parity_bad,
  input  logic  stop_bad,
  input  logic  read_rx_byte,
  input  logic  clear_parity,
  input  logic  clear_framing_error,
  output data_t rx_byte,
  output logic  receive_full,
  output logic  overflow,
  output logic  parity_err,
  output logic  framing_error
);

  // ------------------------------------------------------------------------
  // byte register and handshake
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte      <= '0;
      receive_full <= 1'b0;
      overflow     <= 1'b0;
    end
    else
    begin
      if (read_rx_byte)
      begin
        receive_full <= 1'b0;
        overflow     <= 1'b0;
      end
      if (frame_done)
      begin
        if (!receive_full)
        begin
          rx_byte      <= frame_data;
          receive_full <= 1'b1;
        end
        else
        begin
          overflow <= 1'b1;  // unread byte is kept
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // error flags
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (parity_bad)
        parity_err <= 1'b1;
      else if (clear_parity)
        parity_err <= 1'b0;

      if (stop_bad)
        framing_error <= 1'b1;
      else if (clear_framing_error)
        framing_error <= 1'b0;
    end
  end

endmodule

// ==== uart_rx.sv ====
// top level of the oversampled serial receiver
// the filtered line feeds the frame machine and the parity checker side by
// side, the status block merges their results into the byte and flags

module uart_rx
  import uart_frame_pkg::*;
(
  input  logic  clk,
  input  logic  aresetn,
  input  logic  baud_tick,            // 16 ticks per bit
  input  logic  rx,
  input  logic  bit8,
  input  logic  parity_en,
  input  logic  odd_n_even,
  input  logic  read_rx_byte,
  input  logic  clear_parity,
  input  logic  clear_framing_error,
  output data_t rx_byte,
  output logic  receive_full,
  output logic  overflow,
  output logic  parity_err,
  output logic  framing_error
);

  logic  rx_filtered;
  logic  frame_start;
  logic  bit_sample;
  logic  parity_slot;
  logic  frame_done;
  data_t frame_data;
  logic  stop_bad;
  logic  parity_bad;

  rx_majority_filter i_filter (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_frame_fsm i_frame (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .frame_start (frame_start),
    .bit_sample  (bit_sample),
    .parity_slot (parity_slot),
    .frame_done  (frame_done),
    .frame_data  (frame_data),
    .stop_bad    (stop_bad)
  );

  rx_parity_check i_parity (
    .clk         (clk),
    .aresetn     (aresetn),
    .odd_n_even  (odd_n_even),
    .rx_filtered (rx_filtered),
    .frame_start (frame_start),
    .bit_sample  (bit_sample),
    .parity_slot (parity_slot),
    .parity_bad  (parity_bad)
  );

  rx_status_regs i_status (
    .clk                 (clk),
    .aresetn             (aresetn),
    .frame_done          (frame_done),
    .frame_data          (frame_data),
    .parity_bad          (parity_bad),
    .stop_bad            (stop_bad),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

// ==== rx_monitor.sv ====
// checker of the receiver testbench
// compares the DUT outputs with the expected values on each check cycle,
// prints one line per finished test and the totals when asked

module rx_monitor
  import uart_frame_pkg::*;
(
  input  logic         clk,
  input  logic         check,        // compare on this cycle
  input  logic         test_end,     // close the running test
  input  logic         report,       // print the totals
  input  logic [127:0] test_name,
  input  data_t        exp_byte,
  input  logic         exp_full,
  input  logic         exp_ovf,
  input  logic         exp_perr,
  input  logic         exp_ferr,
  input  data_t        rx_byte,
  input  logic         receive_full,
  input  logic         overflow,
  input  logic         parity_err,
  input  logic         framing_error,
  output int           fail_count
);

  int passes   = 0;
  int failures = 0;
  int errors   = 0;  // errors in the running test

  assign fail_count = failures;

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("mismatch %0s: %0s expected %0b actual %0b", test_name, what, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk)
  begin
    if (check)
    begin
      if (exp_full && !receive_full)
      begin
        $display("%0s: receive_full did not rise after the frame", test_name);
        errors++;
      end
      else
        compare_flag("receive_full", exp_full, receive_full);
      if (rx_byte !== exp_byte)
      begin
        $display("mismatch %0s: rx_byte expected %h actual %h", test_name, exp_byte, rx_byte);
        errors++;
      end
      compare_flag("overflow", exp_ovf, overflow);
      compare_flag("parity_err", exp_perr, parity_err);
      compare_flag("framing_error", exp_ferr, framing_error);
    end
    if (test_end)
    begin
      if (errors == 0)
      begin
        passes++;
        $display("test %0s passed", test_name);
      end
      else
      begin
        failures++;
        $display("test %0s failed with %0d errors", test_name, errors);
      end
      errors = 0;
    end
    if (report)
      $display("tests passed: %0d, tests failed: %0d", passes, failures);
  end

endmodule

// ==== tb_uart_rx.sv ====
// testbench of the serial receiver
// reads one test per line from uart_rx_stim.txt, sends the frame bit by bit on
// rx at 16 baud ticks per bit and lets rx_monitor compare the outputs, once
// after the frame and once after the read and clear strobes

module tb_uart_rx
  import uart_frame_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int GLITCH_TICK = 8;  // close to the sample point of the filter

  logic  clk;
  logic  aresetn;
  logic  baud_tick;
  logic  rx;
  logic  bit8;
  logic  parity_en;
  logic  odd_n_even;
  logic  read_rx_byte;
  logic  clear_parity;
  logic  clear_framing_error;
  data_t rx_byte;
  logic  receive_full;
  logic  overflow;
  logic  parity_err;
  logic  framing_error;

  logic [1:0]   tick_div;
  logic         check;
  logic         test_end;
  logic         report;
  logic [127:0] cur_name;
  data_t        exp_byte;
  logic         exp_full;
  logic         exp_ovf;
  logic         exp_perr;
  logic         exp_ferr;
  int           fail_count;
  int           tb_errors = 0;
  logic         loaded = 1'b0;
  string        lines[$];  // stimulus lines without comments

  uart_rx i_uart_rx (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  rx_monitor i_rx_monitor (
    .clk           (clk),
    .check         (check),
    .test_end      (test_end),
    .report        (report),
    .test_name     (cur_name),
    .exp_byte      (exp_byte),
    .exp_full      (exp_full),
    .exp_ovf       (exp_ovf),
    .exp_perr      (exp_perr),
    .exp_ferr      (exp_ferr),
    .rx_byte       (rx_byte),
    .receive_full  (receive_full),
    .overflow      (overflow),
    .parity_err    (parity_err),
    .framing_error (framing_error),
    .fail_count    (fail_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one baud tick every 4 clocks
  always @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_div  <= 2'd0;
      baud_tick <= 1'b0;
    end
    else
    begin
      tick_div  <= tick_div + 2'd1;
      baud_tick <= (tick_div == 2'd3);
    end
  end

  // ------------------------------------------------------------------------
  // line driving
  // ------------------------------------------------------------------------
  task automatic wait_ticks(input int n);
    repeat (n)
    begin
      @(posedge clk);
      while (!baud_tick)
        @(posedge clk);
    end
  endtask

  // holds one bit for a full bit period, glitch_at < 0 means a clean bit
  task automatic send_bit(input logic v, input int glitch_at);
    for (int t = 0; t < OVERSAMPLE; t++)
    begin
      wait_ticks(1);
      rx <= (t == glitch_at) ? ~v : v;
    end
  endtask

  task automatic send_frame(input logic b8, input logic pen, input logic odd,
                            input logic [7:0] data, input logic pflip,
                            input logic stop, input logic [3:0] glitch);
    logic [7:0] sent;
    logic       par;
    int         nbits;
    sent  = b8 ? data : {1'b0, data[6:0]};
    nbits = b8 ? 8 : 7;
    par   = ^sent ^ odd ^ pflip;  // even rule gives the xor of the data
    send_bit(1'b0, -1);
    for (int k = 0; k < nbits; k++)
      send_bit(data[k], (int'(glitch) == k) ? GLITCH_TICK : -1);
    if (pen)
      send_bit(par, -1);
    send_bit(stop, -1);
  endtask

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------
  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen("uart_rx_stim.txt", "r");
    if (fd == 0)
      $display("could not open the stimulus file uart_rx_stim.txt");
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line.getc(0) != "#")
          lines.push_back(line);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input string line);
    logic [127:0] name;
    logic         b8, pen, odd, pflip, stop, rd, clr;
    logic         efull, eovf, eperr, eferr;
    logic [7:0]   data, ebyte;
    logic [3:0]   glitch;
    int           n;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name, b8, pen,
                odd, data, pflip, stop, glitch, rd, clr, ebyte, efull, eovf, eperr, eferr);
    if (n != 15)
    begin
      $display("stimulus line could not be parsed: %0s", line);
      tb_errors++;
    end
    else
    begin
      @(posedge clk);
      bit8       <= b8;
      parity_en  <= pen;
      odd_n_even <= odd;
      send_frame(b8, pen, odd, data, pflip, stop, glitch);
      send_bit(1'b1, -1);  // covers the stop check and the wait state
      send_bit(1'b1, -1);
      cur_name <= name;
      exp_byte <= ebyte;
      exp_full <= efull;
      exp_ovf  <= eovf;
      exp_perr <= eperr;
      exp_ferr <= eferr;
      check    <= 1'b1;
      @(posedge clk);
      check               <= 1'b0;
      read_rx_byte        <= rd;
      clear_parity        <= clr;
      clear_framing_error <= clr;
      @(posedge clk);
      read_rx_byte        <= 1'b0;
      clear_parity        <= 1'b0;
      clear_framing_error <= 1'b0;
      exp_full <= efull & ~rd;  // a read drops full and overflow
      exp_ovf  <= eovf & ~rd;
      exp_perr <= eperr & ~clr;
      exp_ferr <= eferr & ~clr;
      check    <= 1'b1;
      @(posedge clk);
      check    <= 1'b0;
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
      wait_ticks(int'($urandom % 16));
    end
  endtask

  initial
  begin
    aresetn             <= 1'b0;
    rx                  <= 1'b1;
    bit8                <= 1'b1;
    parity_en           <= 1'b0;
    odd_n_even          <= 1'b0;
    read_rx_byte        <= 1'b0;
    clear_parity        <= 1'b0;
    clear_framing_error <= 1'b0;
    check               <= 1'b0;
    test_end            <= 1'b0;
    report              <= 1'b0;
    cur_name            <= '0;
    exp_byte            <= '0;
    exp_full            <= 1'b0;
    exp_ovf             <= 1'b0;
    exp_perr            <= 1'b0;
    exp_ferr            <= 1'b0;
    void'($urandom(32'h09eefff9));
    load_stimulus();
    if (lines.size() == 0)
    begin
      $display("no tests were found in the stimulus file");
      $display("Simulation finished: FAIL");
      $finish;
    end
    else
    begin
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      aresetn <= 1'b1;
      wait_ticks(4);
      foreach (lines[i])
        run_test(lines[i]);
      report <= 1'b1;
      @(posedge clk);
      report <= 1'b0;
      @(posedge clk);
      if (fail_count == 0 && tb_errors == 0)
        $display("Simulation finished: PASS");
      else
        $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // watchdog, 14 bit periods per test with twice the margin
  initial
  begin
    int limit;
    wait (loaded);
    limit = lines.size() * 14 * OVERSAMPLE * 4 * CLK_PERIOD * 2;
    #(limit);
    $display("timeout: the tests did not finish within %0d time units", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== uart_rx_stim.txt ====
# name b8 par_en odd data par_flip stop glitch_bit(f none) read clear
#   exp_byte exp_full exp_overflow exp_parity_err exp_framing_error (all hex)
b8_basic    1 0 0 a5 0 1 f 1 1 a5 1 0 0 0
b8_zero     1 0 0 00 0 1 f 1 1 00 1 0 0 0
b8_ones     1 0 0 ff 0 1 f 1 1 ff 1 0 0 0
b7_nopar    0 0 0 d3 0 1 f 1 1 53 1 0 0 0
b7_even     0 1 0 b1 0 1 f 1 1 31 1 0 0 0
b7_odd      0 1 1 2c 0 1 f 1 1 2c 1 0 0 0
b8_odd      1 1 1 96 0 1 f 1 1 96 1 0 0 0
b8_even_bad 1 1 0 3c 1 1 f 1 0 3c 1 0 1 0
perr_held   1 0 0 5a 0 1 f 1 1 5a 1 0 1 0
b7_odd_bad  0 1 1 fe 1 1 f 1 1 7e 1 0 1 0
stop_low    1 0 0 c3 0 0 f 1 0 c3 1 0 0 1
ferr_held   1 0 0 18 0 1 f 1 1 18 1 0 0 1
ovf_first   1 0 0 11 0 1 f 0 0 11 1 0 0 0
ovf_second  1 0 0 22 0 1 f 1 0 11 1 1 0 0
glitch_b8   1 0 0 69 0 1 3 1 0 69 1 0 0 0
glitch_hi   1 0 0 80 0 1 7 1 0 80 1 0 0 0
glitch_b7p  0 1 0 35 0 1 0 1 0 35 1 0 0 0

// ==== uart_rx.f ====
uart_frame_pkg.sv
uart_rx_pkg.sv
rx_majority_filter.sv
rx_frame_fsm.sv
rx_parity_check.sv
rx_status_regs.sv
uart_rx.sv
rx_monitor.sv
tb_uart_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the receiver testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_uart_rx -f uart_rx.f

output=$(./obj_dir/Vtb_uart_rx)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi
